/* hdl/apb_defines.svh */
`ifndef APB_DEFINES_SVH
`define APB_DEFINES_SVH

// Bus widths
`define APB_ADDR_W      32
`define APB_DATA_W      32

// Slave memory, addresses at or above the size take the error path
`define APB_MEM_WORDS   256
`define APB_MEM_IDX_W   8

// Request buffer entries, equal to the host credits after reset
`define APB_REQ_DEPTH   4

// Pointer and occupancy width, must hold APB_REQ_DEPTH itself
`define APB_PTR_W       3

`endif

/* hdl/apb_pkg.sv */
`default_nettype none

`include "apb_defines.svh"

package apb_pkg;

    // Master FSM states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SETUP  = 2'b01,
        ACCESS = 2'b10
    } apb_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } apb_op_e;

    // Host request
    typedef struct packed {
        apb_op_e                op;
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
    } apb_req_t;

    // Result returned to the host
    typedef struct packed {
        apb_op_e                op;
        logic [`APB_DATA_W-1:0] rdata;
        logic                   slverr;
    } apb_rsp_t;

    // Master to slave
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
    } apb_bus_req_t;

    // Slave to master
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_bus_rsp_t;

endpackage

`default_nettype wire

/* hdl/apb_req_fifo.sv */
`default_nettype none

`include "apb_defines.svh"

module apb_req_fifo (
    input  logic              vif,
    input  logic              PRESETn,
    input  logic              req_valid,
    input  apb_pkg::apb_req_t req,
    input  logic              pop,
    output logic              head_valid,
    output apb_pkg::apb_req_t head_req,
    output logic              credit_return
);
    import apb_pkg::*;

    localparam int IDX_W = $clog2(`APB_REQ_DEPTH);

    apb_req_t              entries [`APB_REQ_DEPTH];
    logic [`APB_PTR_W-1:0] wr_ptr;
    logic [`APB_PTR_W-1:0] rd_ptr;
    logic [`APB_PTR_W-1:0] count;
    logic                  take;

    // Wrap at the buffer depth, not at the pointer width
    function automatic logic [`APB_PTR_W-1:0] next_ptr(input logic [`APB_PTR_W-1:0] ptr);
        if (ptr == `APB_PTR_W'(`APB_REQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign take       = pop && head_valid;
    assign head_req   = entries[rd_ptr[IDX_W-1:0]];

    // One credit back for every entry the master takes
    assign credit_return = take;

    // Host credits keep the buffer from ever overflowing
    always_ff @(posedge vif) begin
        if (req_valid) begin
            entries[wr_ptr[IDX_W-1:0]] <= req;
        end
    end

    always_ff @(posedge vif or negedge PRESETn) begin
        if (!PRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge vif or negedge PRESETn) begin
        if (!PRESETn) begin
            count <= '0;
        end else begin
            case ({req_valid, take})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/apb_master_fsm.sv */
`default_nettype none

module apb_master_fsm (
    input  logic                  vif,
    input  logic                  PRESETn,
    input  logic                  head_valid,
    input  apb_pkg::apb_req_t     head_req,
    input  apb_pkg::apb_bus_rsp_t bus_rsp,
    output logic                  pop,
    output apb_pkg::apb_bus_req_t bus_req,
    output logic                  rsp_valid,
    output apb_pkg::apb_rsp_t     rsp
);
    import apb_pkg::*;

    apb_state_e state;
    apb_state_e state_nxt;
    apb_req_t   cur_req;
    logic       done;

    // Last ACCESS cycle of a transfer
    assign done = (state == ACCESS) && bus_rsp.pready;

    // Take a new entry from IDLE, or straight out of a finishing ACCESS
    assign pop = head_valid && ((state == IDLE) || done);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (head_valid) begin
                    state_nxt = SETUP;
                end
            end
            SETUP: begin
                state_nxt = ACCESS;
            end
            ACCESS: begin
                if (bus_rsp.pready) begin
                    // Back-to-back skips IDLE
                    state_nxt = head_valid ? SETUP : IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge vif or negedge PRESETn) begin
        if (!PRESETn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Held from SETUP through the end of ACCESS
    always_ff @(posedge vif) begin
        if (pop) begin
            cur_req <= head_req;
        end
    end

    // Bus phase decode
    always_comb begin
        bus_req.paddr   = cur_req.addr;
        bus_req.pwdata  = cur_req.wdata;
        bus_req.pwrite  = (cur_req.op == OP_WRITE);
        bus_req.psel    = (state != IDLE);
        bus_req.penable = (state == ACCESS);
    end

    // Response pulse, host has to take it
    assign rsp_valid = done;

    always_comb begin
        rsp.op     = cur_req.op;
        rsp.rdata  = bus_rsp.prdata;
        rsp.slverr = bus_rsp.pslverr;
    end

endmodule

`default_nettype wire

/* hdl/apb_mem_slave.sv */
`default_nettype none

`include "apb_defines.svh"

module apb_mem_slave (
    input  logic                  vif,
    input  logic                  PRESETn,
    input  apb_pkg::apb_bus_req_t bus_req,
    output apb_pkg::apb_bus_rsp_t bus_rsp
);
    import apb_pkg::*;

    logic [`APB_DATA_W-1:0]    mem [`APB_MEM_WORDS];
    logic [`APB_MEM_IDX_W-1:0] idx;
    logic                      addr_err;
    logic                      access_first;
    logic [`APB_DATA_W-1:0]    prdata_q;
    logic                      pready_q;
    logic                      pslverr_q;

    assign idx      = bus_req.paddr[`APB_MEM_IDX_W-1:0];
    assign addr_err = (bus_req.paddr >= `APB_ADDR_W'(`APB_MEM_WORDS));

    // Ready comes one cycle into ACCESS, so every ACCESS is two cycles
    assign access_first = bus_req.psel && bus_req.penable && !pready_q;

    always_ff @(posedge vif or negedge PRESETn) begin
        if (!PRESETn) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= access_first;
            pslverr_q <= access_first && addr_err;
        end
    end

    // Out-of-range writes are dropped, out-of-range reads return zero
    always_ff @(posedge vif) begin
        if (access_first) begin
            if (bus_req.pwrite && !addr_err) begin
                mem[idx] <= bus_req.pwdata;
            end
            if (!bus_req.pwrite && !addr_err) begin
                prdata_q <= mem[idx];
            end else begin
                prdata_q <= '0;
            end
        end
    end

    always_comb begin
        bus_rsp.prdata  = prdata_q;
        bus_rsp.pready  = pready_q;
        bus_rsp.pslverr = pslverr_q;
    end

endmodule

`default_nettype wire

/* hdl/apb_bridge_top.sv */
`default_nettype none

module apb_bridge_top (
    input  logic              vif,
    input  logic              PRESETn,
    input  logic              req_valid,
    input  apb_pkg::apb_req_t req,
    output logic              credit_return,
    output logic              rsp_valid,
    output apb_pkg::apb_rsp_t rsp
);
    import apb_pkg::*;

    logic         head_valid;
    apb_req_t     head_req;
    logic         pop;
    apb_bus_req_t bus_req;
    apb_bus_rsp_t bus_rsp;

    apb_req_fifo u_req_fifo (
        .vif           (vif),
        .PRESETn       (PRESETn),
        .req_valid     (req_valid),
        .req           (req),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_req      (head_req),
        .credit_return (credit_return)
    );

    apb_master_fsm u_master (
        .vif        (vif),
        .PRESETn    (PRESETn),
        .head_valid (head_valid),
        .head_req   (head_req),
        .bus_rsp    (bus_rsp),
        .pop        (pop),
        .bus_req    (bus_req),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    apb_mem_slave u_slave (
        .vif     (vif),
        .PRESETn (PRESETn),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

`default_nettype wire

/* tests/apb_bridge_assert.sv */
`default_nettype none

module apb_bridge_assert (
    input logic                  vif,
    input logic                  PRESETn,
    input apb_pkg::apb_bus_req_t bus_req,
    input apb_pkg::apb_bus_rsp_t bus_rsp,
    input logic                  rsp_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import apb_pkg::*;

    logic setup_phase;
    logic access_phase;

    assign setup_phase  = bus_req.psel && !bus_req.penable;
    assign access_phase = bus_req.psel && bus_req.penable;

    // SETUP lasts a single cycle
    setup_to_access: assert property (
        @(posedge vif) disable iff (!PRESETn) setup_phase |=> access_phase
    ) else $error("SETUP cycle not followed by ACCESS");

    // Transfer attributes hold until the ready cycle
    ctrl_stable: assert property (
        @(posedge vif) disable iff (!PRESETn)
        (setup_phase || (access_phase && !bus_rsp.pready)) |=>
            ($stable(bus_req.paddr) && $stable(bus_req.pwrite) && $stable(bus_req.pwdata))
    ) else $error("paddr, pwrite or pwdata changed during a transfer");

    ready_in_access: assert property (
        @(posedge vif) disable iff (!PRESETn) bus_rsp.pready |-> access_phase
    ) else $error("pready high outside ACCESS");

    // Every slave ready completes exactly one response
    rsp_with_ready: assert property (
        @(posedge vif) disable iff (!PRESETn) rsp_valid == bus_rsp.pready
    ) else $error("rsp_valid and pready disagree");

endmodule

bind apb_bridge_top apb_bridge_assert u_assert (
    .vif       (vif),
    .PRESETn   (PRESETn),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .rsp_valid (rsp_valid)
);

`default_nettype wire

/* tests/apb_bridge_tb.sv */
`default_nettype none

`include "apb_defines.svh"

module apb_bridge_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import apb_pkg::*;

    // Request in flight with the cycle it was driven
    typedef struct packed {
        apb_req_t    req;
        logic [31:0] cycle;
    } pending_t;

    localparam int TIMEOUT_CYCLES = 200;

    logic     vif;
    logic     PRESETn;
    logic     req_valid;
    apb_req_t req;
    logic     credit_return;
    logic     rsp_valid;
    apb_rsp_t rsp;

    integer      seed;
    int          credits;
    int          credit_pulses;
    int          rsp_count;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    logic        timed_out;
    logic [31:0] cycle_cnt;
    logic [31:0] last_latency;
    pending_t    pending [$];
    logic [31:0] rsp_cycles [$];
    logic [`APB_DATA_W-1:0] ref_mem [int];

    apb_bridge_top u_dut (
        .vif           (vif),
        .PRESETn       (PRESETn),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

    always #20 vif = ~vif;

    always @(posedge vif or negedge PRESETn) begin
        if (!PRESETn) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic check_data(input string name, input logic [`APB_DATA_W-1:0] got,
                              input logic [`APB_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_slverr(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_op(input string name, input apb_op_e got, input apb_op_e exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // Expected result follows from the address range and the reference memory
    task automatic score_response();
        pending_t        p;
        logic            exp_err;
        logic [`APB_MEM_IDX_W-1:0] idx;
        if (pending.size() == 0) begin
            $display("Response arrived with no request outstanding");
            error_count++;
            return;
        end
        p = pending.pop_front();
        idx = p.req.addr[`APB_MEM_IDX_W-1:0];
        exp_err = (p.req.addr >= `APB_MEM_WORDS);
        last_latency = cycle_cnt - p.cycle;
        check_op("rsp.op", rsp.op, p.req.op);
        check_slverr("rsp.slverr", rsp.slverr, exp_err);
        if (p.req.op == OP_READ) begin
            if (exp_err) begin
                check_data("rsp.rdata", rsp.rdata, '0);
            end else if (ref_mem.exists(idx)) begin
                check_data("rsp.rdata", rsp.rdata, ref_mem[idx]);
            end else begin
                $display("Read of address 0x%h, which was never written", p.req.addr);
                error_count++;
            end
        end else if (!exp_err) begin
            ref_mem[idx] = p.req.wdata;
        end
    endtask

    // Host side monitor
    always @(negedge vif) begin
        if (PRESETn) begin
            if (credit_return) begin
                credits++;
                credit_pulses++;
            end
            if (rsp_valid) begin
                rsp_count++;
                rsp_cycles.push_back(cycle_cnt);
                score_response();
            end
        end
    end

    task automatic wait_credit();
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            req_valid = 1'b0;
            @(posedge vif);
            #2;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: no credit came back from the DUT");
                timed_out = 1'b1;
                error_count++;
            end
        end
    endtask

    task automatic send_req(input apb_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        pending_t p;
        @(posedge vif);
        #2;
        wait_credit();
        if (timed_out) begin
            req_valid = 1'b0;
            return;
        end
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        credits--;
        p.req   = req;
        p.cycle = cycle_cnt;
        pending.push_back(p);
    endtask

    task automatic idle_bus();
        @(posedge vif);
        #2;
        req_valid = 1'b0;
    endtask

    // All responses back and all credits returned
    task automatic wait_idle();
        int waited;
        waited = 0;
        idle_bus();
        while ((pending.size() != 0 || credits != `APB_REQ_DEPTH) && !timed_out) begin
            @(posedge vif);
            #2;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: responses or credits still outstanding");
                timed_out = 1'b1;
                error_count++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        int pulses;
        errs = error_count;
        @(negedge vif);
        check_slverr("rsp_valid", rsp_valid, 1'b0);
        check_slverr("credit_return", credit_return, 1'b0);
        if (credits != `APB_REQ_DEPTH) begin
            $display("Host holds %0d credits after reset", credits);
            error_count++;
        end
        pulses = credit_pulses;
        for (int i = 0; i < `APB_REQ_DEPTH; i++) begin
            send_req(OP_WRITE, 32'h20 + i, $random(seed));
        end
        wait_idle();
        if (credit_pulses - pulses != `APB_REQ_DEPTH) begin
            $display("credit_return pulsed %0d times for the first %0d requests",
                     credit_pulses - pulses, `APB_REQ_DEPTH);
            error_count++;
        end
        finish_test("reset", errs);
    endtask

    task automatic test_write_read();
        int          errs;
        logic [31:0] addrs [8];
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & (`APB_MEM_WORDS - 1);
            send_req(OP_WRITE, addrs[i], $random(seed));
        end
        wait_idle();
        for (int i = 0; i < 8; i++) begin
            send_req(OP_READ, addrs[i], '0);
        end
        wait_idle();
        // Isolated request
        send_req(OP_READ, addrs[0], '0);
        wait_idle();
        if (last_latency !== 32'd4) begin
            $display("FAILED rsp_valid latency: got 0x%h, expected 0x%h", last_latency, 32'd4);
            error_count++;
        end
        finish_test("write_read", errs);
    endtask

    task automatic test_out_of_range();
        int errs;
        errs = error_count;
        send_req(OP_WRITE, 32'h0000_0037, $random(seed));
        send_req(OP_WRITE, 32'h0000_0137, $random(seed));
        send_req(OP_READ, 32'h0000_0137, '0);
        send_req(OP_WRITE, 32'hffff_ff37, $random(seed));
        // Same low index still holds the first write
        send_req(OP_READ, 32'h0000_0037, '0);
        wait_idle();
        finish_test("out_of_range", errs);
    endtask

    task automatic test_burst();
        int errs;
        int pulses;
        errs = error_count;
        pulses = credit_pulses;
        rsp_cycles.delete();
        send_req(OP_WRITE, 32'h90, $random(seed));
        send_req(OP_READ, 32'h90, '0);
        send_req(OP_WRITE, 32'h91, $random(seed));
        send_req(OP_READ, 32'h91, '0);
        wait_idle();
        if (credit_pulses - pulses != `APB_REQ_DEPTH) begin
            $display("credit_return pulsed %0d times for %0d requests",
                     credit_pulses - pulses, `APB_REQ_DEPTH);
            error_count++;
        end
        for (int i = 1; i < rsp_cycles.size(); i++) begin
            if (rsp_cycles[i] - rsp_cycles[i-1] != 3) begin
                $display("FAILED response spacing: got 0x%h, expected 0x%h",
                         rsp_cycles[i] - rsp_cycles[i-1], 32'd3);
                error_count++;
            end
        end
        finish_test("burst", errs);
    endtask

    task automatic test_stream();
        int          errs;
        int          sent;
        int          seen;
        bit          written [16];
        logic [31:0] r;
        logic [31:0] addr;
        apb_op_e     op;
        errs = error_count;
        sent = 0;
        seen = rsp_count;
        for (int i = 0; i < 16; i++) begin
            written[i] = 1'b0;
        end
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            addr = 32'hc0 + r[3:0];
            op = r[4] ? OP_WRITE : OP_READ;
            if (r[7:5] == 3'd0) begin
                addr = addr | 32'h0001_0000;
            end
            // Only read words that hold data
            if (op == OP_READ && !written[r[3:0]]) begin
                op = OP_WRITE;
            end
            if (op == OP_WRITE && addr < `APB_MEM_WORDS) begin
                written[r[3:0]] = 1'b1;
            end
            send_req(op, addr, $random(seed));
            sent++;
            if (r[9:8] == 2'd0) begin
                idle_bus();
            end
        end
        wait_idle();
        if (rsp_count - seen != sent) begin
            $display("Sent %0d requests but got %0d responses", sent, rsp_count - seen);
            error_count++;
        end
        finish_test("stream", errs);
    endtask

    initial begin
        vif = 1'b0;
        PRESETn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        seed = 32'hef4a_f6ca;
        credits = `APB_REQ_DEPTH;
        credit_pulses = 0;
        rsp_count = 0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        last_latency = '0;
        repeat (8) @(posedge vif);
        #2;
        PRESETn = 1'b1;
        test_reset();
        if (!timed_out) begin
            test_write_read();
        end
        if (!timed_out) begin
            test_out_of_range();
        end
        if (!timed_out) begin
            test_burst();
        end
        if (!timed_out) begin
            test_stream();
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/apb_pkg.sv
hdl/apb_req_fifo.sv
hdl/apb_master_fsm.sv
hdl/apb_mem_slave.sv
hdl/apb_bridge_top.sv
tests/apb_bridge_assert.sv
tests/apb_bridge_tb.sv

/* Bender.yml */
package:
  name: apb_bridge

export_include_dirs:
  - hdl

sources:
  # RTL in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/apb_pkg.sv
      - hdl/apb_req_fifo.sv
      - hdl/apb_master_fsm.sv
      - hdl/apb_mem_slave.sv
      - hdl/apb_bridge_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/apb_bridge_assert.sv
      - tests/apb_bridge_tb.sv
